/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    parameter int SET_BITS    = 6;     // Number of sets is two to this
    parameter int NUM_WAYS    = 4;
    parameter int LINE_WORDS  = 16;
    parameter int OFFSET_BITS = 6;     // Byte offset within a line

    typedef logic [NUM_WAYS-1:0] way_mask_t;

    // Instruction cache operations carried on the request port
    typedef enum logic [1:0] {
        CACOP_STORE_TAG = 2'b00,
        CACOP_INDEX_INV = 2'b01,
        CACOP_HIT_INV   = 2'b10
    } cacop_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        MISS_REQ = 2'd2,
        REFILL   = 2'd3
    } ctrl_state_e;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncache;
        logic        cacop_en;
        cacop_e      cacop;
    } icache_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } icache_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;      // Beats minus one
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rd_ret_t;

endpackage

`default_nettype wire

/* icache.f */
common/icache_pkg.sv
icache/icache_ctrl.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_refill.sv
icache/icache_lru.sv
source/icache_top.sv
testbench/icache_tb.sv

/* icache/icache_ctrl.sv */
`default_nettype none

module icache_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    req_valid,
    input  wire icache_pkg::icache_req_t buf_req,
    input  wire icache_pkg::way_mask_t   hit,
    input  wire icache_pkg::way_mask_t   victim,
    input  wire logic                    mem_req_ready,
    input  wire logic                    fill_done,
    output logic                         req_ready,
    output logic                         buf_load,
    output icache_pkg::way_mask_t        tag_we,
    output logic                         tag_clear,
    output icache_pkg::way_mask_t        data_we,
    output logic                         mem_req_valid,
    output logic                         mem_ret_ready,
    output logic                         refill_start,
    output logic                         lru_touch,
    output icache_pkg::way_mask_t        touch_way,
    output logic                         rsp_valid,
    output logic                         rsp_from_refill
);
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    way_mask_t   index_way;
    logic        any_hit;
    logic        finish;           // Request answered this cycle

    assign any_hit = |hit;

    // Index operations name the way in the low two address bits
    always_comb begin
        index_way = '0;
        index_way[buf_req.addr[1:0]] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        req_ready       = 1'b0;
        tag_we          = '0;
        tag_clear       = 1'b0;
        data_we         = '0;
        mem_req_valid   = 1'b0;
        mem_ret_ready   = 1'b0;
        refill_start    = 1'b0;
        lru_touch       = 1'b0;
        touch_way       = '0;
        rsp_valid       = 1'b0;
        rsp_from_refill = 1'b0;
        finish          = 1'b0;

        case (state_q)
            IDLE: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (buf_req.cacop_en) begin
                    tag_clear = 1'b1;
                    case (buf_req.cacop)
                        CACOP_HIT_INV: tag_we = hit;
                        default:       tag_we = index_way;   // Store-tag and index-invalidate
                    endcase
                    finish = 1'b1;
                end else if (buf_req.uncache || !any_hit) begin
                    state_d = MISS_REQ;
                end else begin
                    lru_touch = 1'b1;
                    touch_way = hit;
                    finish    = 1'b1;
                end
            end
            MISS_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    refill_start = 1'b1;
                    state_d      = REFILL;
                end
            end
            REFILL: begin
                mem_ret_ready = 1'b1;
                if (fill_done) begin
                    if (!buf_req.uncache) begin
                        tag_we    = victim;
                        data_we   = victim;
                        lru_touch = 1'b1;
                        touch_way = victim;
                    end
                    rsp_from_refill = 1'b1;
                    finish          = 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // Answer and take the next request in the same cycle
        if (finish) begin
            rsp_valid = 1'b1;
            req_ready = 1'b1;
            state_d   = req_valid ? LOOKUP : IDLE;
        end
    end

    assign buf_load = req_valid && req_ready;

endmodule

`default_nettype wire

/* icache/icache_data_array.sv */
`default_nettype none

module icache_data_array #(
    parameter int SET_BITS = icache_pkg::SET_BITS
) (
    input  wire logic                                  clk,
    input  wire logic [31:0]                           rd_addr,
    input  wire logic [31:0]                           buf_addr,
    input  wire icache_pkg::way_mask_t                 hit,
    input  wire icache_pkg::way_mask_t                 we,
    input  wire logic [icache_pkg::LINE_WORDS-1:0][31:0] line_in,
    output logic [31:0]                                rdata
);
    import icache_pkg::*;

    localparam int SETS      = 1 << SET_BITS;
    localparam int WORD_BITS = $clog2(LINE_WORDS);

    logic [LINE_WORDS-1:0][31:0] line_mem [NUM_WAYS][SETS];
    logic [LINE_WORDS-1:0][31:0] rd_line [NUM_WAYS];
    logic [SET_BITS-1:0]         rd_index;
    logic [SET_BITS-1:0]         wr_index;
    logic [WORD_BITS-1:0]        word_sel;

    assign rd_index = rd_addr[OFFSET_BITS +: SET_BITS];
    assign wr_index = buf_addr[OFFSET_BITS +: SET_BITS];
    assign word_sel = buf_addr[2 +: WORD_BITS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (we[w]) begin
                line_mem[w][wr_index] <= line_in;
            end
            if (we[w] && (rd_index == wr_index)) begin
                rd_line[w] <= line_in;        // Fresh fill of the set being read
            end else begin
                rd_line[w] <= line_mem[w][rd_index];
            end
        end
    end

    // Hit mask is one-hot, so an OR of the masked words picks the way
    always_comb begin
        rdata = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit[w]) begin
                rdata = rdata | rd_line[w][word_sel];
            end
        end
    end

endmodule

`default_nettype wire

/* icache/icache_lru.sv */
`default_nettype none

module icache_lru #(
    parameter int SET_BITS = icache_pkg::SET_BITS
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic [SET_BITS-1:0]   rd_index,
    input  wire logic                  touch,
    input  wire icache_pkg::way_mask_t touch_way,
    input  wire icache_pkg::way_mask_t valid_mask,
    output icache_pkg::way_mask_t      victim
);
    import icache_pkg::*;

    localparam int SETS = 1 << SET_BITS;

    logic [SETS-1:0][NUM_WAYS-1:0][1:0] age_q;     // Zero is youngest
    logic [NUM_WAYS-1:0][1:0]           set_age;
    logic [1:0]                         touch_age;

    assign set_age = age_q[rd_index];

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (touch_way[w]) begin
                touch_age = touch_age | set_age[w];
            end
        end
    end

    // Ways younger than the touched one age by one
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= 2'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (touch_way[w]) begin
                    age_q[rd_index][w] <= 2'd0;
                end else if (set_age[w] < touch_age) begin
                    age_q[rd_index][w] <= set_age[w] + 2'd1;
                end
            end
        end
    end

    always_comb begin
        victim = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (set_age[w] == 2'(NUM_WAYS - 1)) begin
                victim[w] = 1'b1;
            end
        end
        // Lowest invalid way wins over the oldest
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim    = '0;
                victim[w] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* icache/icache_refill.sv */
`default_nettype none

module icache_refill (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire logic                           start,
    input  wire logic [31:0]                    buf_addr,
    input  wire logic                           ret_valid,
    input  wire logic                           ret_ready,
    input  wire icache_pkg::mem_rd_ret_t        ret,
    output logic [icache_pkg::LINE_WORDS-1:0][31:0] line_out,
    output logic [31:0]                         crit_word,
    output logic                                fill_done
);
    import icache_pkg::*;

    localparam int WORD_BITS = $clog2(LINE_WORDS);

    logic [WORD_BITS-1:0] beat_cnt;
    logic [WORD_BITS-1:0] crit_sel;
    logic                 xfer;
    logic                 take_crit;

    assign xfer     = ret_valid && ret_ready;
    assign crit_sel = buf_addr[2 +: WORD_BITS];

    // A lone last beat at count zero is an uncached word
    assign take_crit = (beat_cnt == crit_sel) || (ret.last && (beat_cnt == '0));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= xfer && ret.last;
            if (start) begin
                beat_cnt <= '0;                // Bursts start at word zero
            end else if (xfer) begin
                beat_cnt <= beat_cnt + WORD_BITS'(1);
            end
        end
    end

    // Line buffer
    always_ff @(posedge clk) begin
        if (xfer) begin
            line_out[beat_cnt] <= ret.data;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && take_crit) begin
            crit_word <= ret.data;
        end
    end

endmodule

`default_nettype wire

/* icache/icache_tag_array.sv */
`default_nettype none

module icache_tag_array #(
    parameter int SET_BITS = icache_pkg::SET_BITS
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic [31:0]           rd_addr,
    input  wire logic [31:0]           buf_addr,
    input  wire icache_pkg::way_mask_t we,
    input  wire logic                  clear,
    output icache_pkg::way_mask_t      hit,
    output icache_pkg::way_mask_t      valid_mask
);
    import icache_pkg::*;

    localparam int SETS     = 1 << SET_BITS;
    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

    logic [TAG_BITS-1:0]           tag_mem [NUM_WAYS][SETS];
    logic [SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [TAG_BITS-1:0]           rd_tag [NUM_WAYS];
    way_mask_t                     rd_valid;
    logic [SET_BITS-1:0]           rd_index;
    logic [SET_BITS-1:0]           wr_index;
    logic [TAG_BITS-1:0]           buf_tag;
    logic [TAG_BITS-1:0]           wr_tag;
    logic                          same_set;

    assign rd_index = rd_addr[OFFSET_BITS +: SET_BITS];
    assign wr_index = buf_addr[OFFSET_BITS +: SET_BITS];
    assign buf_tag  = buf_addr[31 -: TAG_BITS];
    assign wr_tag   = clear ? '0 : buf_tag;      // Store-tag writes a zero tag
    assign same_set = (rd_index == wr_index);

    // Registered read that sees a write to the same set at once
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            if (we[w] && same_set) begin
                rd_tag[w] <= wr_tag;
            end else begin
                rd_tag[w] <= tag_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (we[w]) begin
                    valid_q[wr_index][w] <= !clear;
                end
                if (we[w] && same_set) begin
                    rd_valid[w] <= !clear;
                end else begin
                    rd_valid[w] <= valid_q[rd_index][w];
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == buf_tag);
        end
    end

    assign valid_mask = rd_valid;

endmodule

`default_nettype wire

/* source/icache_top.sv */
`default_nettype none

module icache_top #(
    parameter int SET_BITS = icache_pkg::SET_BITS
) (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    req_valid,
    input  wire icache_pkg::icache_req_t req,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output icache_pkg::icache_rsp_t      rsp,
    output logic                         mem_req_valid,
    output icache_pkg::mem_rd_req_t      mem_req,
    input  wire logic                    mem_req_ready,
    input  wire logic                    mem_ret_valid,
    input  wire icache_pkg::mem_rd_ret_t mem_ret,
    output logic                         mem_ret_ready
);
    import icache_pkg::*;

    icache_req_t                 req_buf;
    logic                        buf_load;
    way_mask_t                   hit;
    way_mask_t                   victim;
    way_mask_t                   valid_mask;
    way_mask_t                   tag_we;
    way_mask_t                   data_we;
    way_mask_t                   touch_way;
    logic                        tag_clear;
    logic                        refill_start;
    logic                        fill_done;
    logic                        lru_touch;
    logic                        rsp_from_refill;
    logic [31:0]                 rd_addr;
    logic [31:0]                 array_word;
    logic [31:0]                 crit_word;
    logic [LINE_WORDS-1:0][31:0] fill_line;

    always_ff @(posedge clk) begin
        if (buf_load) begin
            req_buf <= req;
        end
    end

    // Arrays follow the buffered set unless a new request is taken
    assign rd_addr = buf_load ? req.addr : req_buf.addr;

    assign mem_req.addr = req_buf.uncache ? {req_buf.addr[31:2], 2'b00}
                                          : {req_buf.addr[31:OFFSET_BITS], OFFSET_BITS'(0)};
    assign mem_req.len  = req_buf.uncache ? 8'd0 : 8'(LINE_WORDS - 1);

    assign rsp.rdata = req_buf.cacop_en ? 32'd0 : (rsp_from_refill ? crit_word : array_word);

    icache_ctrl icache_ctrl_inst (
        .clk, .rstn, .req_valid, .buf_req(req_buf), .hit, .victim, .mem_req_ready,
        .fill_done, .req_ready, .buf_load, .tag_we, .tag_clear, .data_we, .mem_req_valid,
        .mem_ret_ready, .refill_start, .lru_touch, .touch_way, .rsp_valid, .rsp_from_refill
    );

    icache_tag_array #(.SET_BITS(SET_BITS)) icache_tag_array_inst (
        .clk, .rstn, .rd_addr, .buf_addr(req_buf.addr), .we(tag_we), .clear(tag_clear),
        .hit, .valid_mask
    );

    icache_data_array #(.SET_BITS(SET_BITS)) icache_data_array_inst (
        .clk, .rd_addr, .buf_addr(req_buf.addr), .hit, .we(data_we), .line_in(fill_line),
        .rdata(array_word)
    );

    icache_refill icache_refill_inst (
        .clk, .rstn, .start(refill_start), .buf_addr(req_buf.addr), .ret_valid(mem_ret_valid),
        .ret_ready(mem_ret_ready), .ret(mem_ret), .line_out(fill_line), .crit_word, .fill_done
    );

    icache_lru #(.SET_BITS(SET_BITS)) icache_lru_inst (
        .clk, .rstn, .rd_index(req_buf.addr[OFFSET_BITS +: SET_BITS]), .touch(lru_touch),
        .touch_way, .valid_mask, .victim
    );

endmodule

`default_nettype wire

/* testbench/icache_tb.sv */
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int TAG_BITS  = 32 - SET_BITS - OFFSET_BITS;
    localparam int SETS      = 1 << SET_BITS;
    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT   = 200;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    icache_req_t req;
    logic        req_ready;
    logic        rsp_valid;
    icache_rsp_t rsp;
    logic        mem_req_valid;
    mem_rd_req_t mem_req;
    logic        mem_req_ready;
    logic        mem_ret_valid;
    mem_rd_ret_t mem_ret;
    logic        mem_ret_ready;

    logic [31:0]         trace_mem [4*MAX_TESTS];
    logic [TAG_BITS-1:0] m_tag [SETS][NUM_WAYS];     // Shadow cache state
    logic                m_valid [SETS][NUM_WAYS];
    int                  m_age [SETS][NUM_WAYS];
    logic [31:0]         lfsr;
    int                  errors;
    int                  tests;
    int                  failed;
    logic                hung;

    icache_top #(.SET_BITS(SET_BITS)) icache_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5A5A0000;
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'd0:    return "read";
            4'd1:    return "store_tag";
            4'd2:    return "index_inv";
            4'd3:    return "hit_inv";
            default: return "unknown";
        endcase
    endfunction

    task automatic step_clk();
        @(posedge clk);
        #1;
    endtask

    task automatic note_failure(input string name, input string what);
        errors++;
        $display("%s: %s", name, what);
    endtask

    task automatic check_rsp(input string name, input icache_rsp_t exp, input icache_rsp_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected rdata %h actual rdata %h", name, exp.rdata, act.rdata);
        end
    endtask

    task automatic check_mem_req(input string name, input mem_rd_req_t exp,
                                 input mem_rd_req_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected addr %h len %0d actual addr %h len %0d",
                     name, exp.addr, exp.len, act.addr, act.len);
        end
    endtask

    task automatic check_hit(input string name, input logic exp_hit, input logic mem_seen);
        if (exp_hit !== !mem_seen) begin
            errors++;
            $display("Error %s: expected hit %0d actual hit %0d", name, exp_hit, !mem_seen);
        end
    endtask

    task automatic model_touch(input int set, input int way);
        int t;
        t = m_age[set][way];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) begin
                m_age[set][w] = 0;
            end else if (m_age[set][w] < t) begin
                m_age[set][w]++;
            end
        end
    endtask

    // Reference replacement takes the lowest invalid way or else the oldest
    task automatic model_access(input logic [3:0] op, input logic [31:0] addr, input logic unc,
                                output logic hit_pred);
        int                  set;
        int                  way;
        logic [TAG_BITS-1:0] tag;
        set      = int'(addr[OFFSET_BITS +: SET_BITS]);
        tag      = addr[31 -: TAG_BITS];
        way      = -1;
        hit_pred = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
        end
        case (op)
            4'd0: begin
                if (!unc && way >= 0) begin
                    hit_pred = 1'b1;
                    model_touch(set, way);
                end else if (!unc) begin
                    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                        if (!m_valid[set][w]) way = w;
                    end
                    for (int w = 0; w < NUM_WAYS && way < 0; w++) begin
                        if (m_age[set][w] == NUM_WAYS - 1) way = w;
                    end
                    m_tag[set][way]   = tag;
                    m_valid[set][way] = 1'b1;
                    model_touch(set, way);
                end
            end
            4'd1, 4'd2: m_valid[set][addr[1:0]] = 1'b0;
            4'd3: if (way >= 0) m_valid[set][way] = 1'b0;
            default: ;
        endcase
    endtask

    // Memory model answers after a random accept delay and sends beats with random gaps
    task automatic serve_mem(input string name, input mem_rd_req_t exp);
        int          delay;
        int          stall;
        mem_rd_req_t act;
        take_bits(2, delay);
        step_clk();
        repeat (delay) step_clk();
        mem_req_ready = 1'b1;
        @(negedge clk);
        if (!mem_req_valid) note_failure(name, "memory request dropped before it was accepted");
        act = mem_req;
        check_mem_req(name, exp, act);
        step_clk();
        mem_req_ready = 1'b0;
        for (int b = 0; b <= int'(act.len); b++) begin
            take_bits(2, stall);
            repeat (stall) begin
                @(negedge clk);
                if (req_ready || rsp_valid) note_failure(name, "fetch side not held off in refill");
                step_clk();
            end
            mem_ret.data  = mem_word(act.addr + 32'(4 * b));
            mem_ret.last  = (b == int'(act.len));
            mem_ret_valid = 1'b1;
            @(negedge clk);
            if (!mem_ret_ready) note_failure(name, "mem_ret_ready low while a beat is offered");
            if (req_ready || rsp_valid) note_failure(name, "fetch side not held off in refill");
            step_clk();
            mem_ret_valid = 1'b0;
        end
    endtask

    task automatic run_test(input int idx, input logic [3:0] op, input logic [31:0] addr,
                            input logic unc, input logic exp_hit);
        string       name;
        icache_req_t r;
        icache_rsp_t exp_rsp;
        icache_rsp_t act;
        mem_rd_req_t exp_mem;
        logic        model_hit;
        logic        accepted;
        logic        got;
        logic        mem_seen;
        logic        served;
        int          cycles;
        int          errs_before;
        name        = $sformatf("test%0d_%s_%h", idx, op_name(op), addr);
        errs_before = errors;
        r.addr      = addr;
        r.uncache   = unc;
        r.cacop_en  = (op != 4'd0);
        case (op)
            4'd2:    r.cacop = CACOP_INDEX_INV;
            4'd3:    r.cacop = CACOP_HIT_INV;
            default: r.cacop = CACOP_STORE_TAG;
        endcase
        exp_rsp.rdata = (op == 4'd0) ? mem_word(addr & ~32'd3) : 32'd0;
        exp_mem.addr  = unc ? (addr & ~32'd3) : (addr & ~32'(LINE_WORDS * 4 - 1));
        exp_mem.len   = unc ? 8'd0 : 8'(LINE_WORDS - 1);
        model_access(op, addr, unc, model_hit);
        if (model_hit !== exp_hit) note_failure(name, "trace hit flag disagrees with the model");

        req       = r;
        req_valid = 1'b1;
        accepted  = 1'b0;
        cycles    = 0;
        while (!accepted && !hung) begin
            @(negedge clk);
            cycles++;
            if (req_ready) begin
                accepted = 1'b1;
            end else if (cycles > TIMEOUT) begin
                hung = 1'b1;
                $display("%s: request not accepted within %0d cycles", name, TIMEOUT);
            end
        end
        step_clk();
        req_valid = 1'b0;

        got      = 1'b0;
        mem_seen = 1'b0;
        served   = 1'b0;
        cycles   = 0;
        while (!got && !hung) begin
            @(negedge clk);
            cycles++;
            if (rsp_valid) begin
                got = 1'b1;
                act = rsp;
            end else begin
                if (served) begin
                    note_failure(name, "no response in the cycle after the last beat");
                    served = 1'b0;
                end
                if (req_ready) note_failure(name, "req_ready high while the request is pending");
                if (mem_req_valid && !mem_seen) begin
                    mem_seen = 1'b1;
                    serve_mem(name, exp_mem);
                    served = 1'b1;
                end else if (cycles > TIMEOUT) begin
                    hung = 1'b1;
                    $display("%s: no response within %0d cycles", name, TIMEOUT);
                end
            end
        end
        step_clk();

        if (!hung) begin
            check_rsp(name, exp_rsp, act);
            if (op == 4'd0) begin
                check_hit(name, exp_hit, mem_seen);
            end else if (mem_seen) begin
                note_failure(name, "memory request issued for a cache operation");
            end
            if ((op != 4'd0 || exp_hit) && cycles != 1) begin
                errors++;
                $display("Error %s: expected latency 1 actual latency %0d", name, cycles);
            end
        end
        tests++;
        if (errors != errs_before) failed++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] op;
        clk           = 1'b0;
        rstn          = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        mem_req_ready = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret       = '0;
        lfsr          = 32'h1235;
        errors        = 0;
        tests         = 0;
        failed        = 0;
        hung          = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end
        $readmemh("testbench/icache_trace.txt", trace_mem);
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < MAX_TESTS; i++) begin
            op = trace_mem[4*i];
            if (op === 32'hF || $isunknown(op)) break;
            run_test(i, op[3:0], trace_mem[4*i+1], trace_mem[4*i+2][0], trace_mem[4*i+3][0]);
            if (hung) break;
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !hung && tests > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/icache_trace.txt */
// Columns: op (0 read, 1 store-tag, 2 index-inv, 3 hit-inv, f end of trace),
//          address, uncache flag, expected hit (reads only)
0 00001000 0 0
0 00001000 0 1
0 0000103C 0 1
0 00001024 0 1
0 00005008 1 0
0 00005008 0 0
0 00005008 0 1
// Five lines in set 1, then the first one again
0 00010040 0 0
0 00020040 0 0
0 00030040 0 0
0 00040040 0 0
0 00050040 0 0
0 00010044 0 0
0 00030040 0 1
0 00020040 0 0
2 00000042 0 0
0 00030048 0 0
0 00050040 0 1
3 00010040 0 0
0 00010050 0 0
0 00020040 0 1
0 00030040 0 1
1 00000001 0 0
0 00005000 0 0
0 00001004 0 1
3 00009000 0 0
0 00001008 0 1
0 0000A00C 1 0
0 00000FFC 0 0
0 00000FF0 0 1
F 00000000 0 0
